//--- logic/minisys_pkg.sv
`default_nettype none

package minisys_pkg;

    // Access width of one bus transfer
    typedef enum logic [1:0] {
        WIDTH_BYTE = 2'd0,
        WIDTH_HALF = 2'd1,
        WIDTH_WORD = 2'd2
    } width_t;

    // One request from the bus master, held stable until ack
    typedef struct packed {
        logic        write;      // 1 = store, 0 = load
        width_t      width;
        logic        sign;       // Sign-extend byte/half loads
        logic [15:0] addr;       // Byte address
        logic [31:0] wdata;      // Store data, right aligned
    } bus_req_t;

    // Bus controller sequencing
    typedef enum logic [1:0] {
        BUS_IDLE   = 2'd0,
        BUS_ACCESS = 2'd1,
        BUS_ACK    = 2'd2
    } bus_state_t;

    // Source of the latched read data
    typedef enum logic [1:0] {
        RD_NONE   = 2'd0,
        RD_RAM    = 2'd1,
        RD_SWITCH = 2'd2
    } rd_sel_t;

    // I/O space is everything with the top six address bits set
    localparam logic [15:0] IO_BASE       = 16'hFC00;

    // PWM registers: +0 period, +2 compare, +4 enable
    localparam logic [15:0] PWM_ADDR_BASE = 16'hFC30;

    // LED bits 15:0 at +0, bits 23:16 at +2
    localparam logic [15:0] LED_ADDR      = 16'hFC60;

    // Switch bits 15:0 at +0, bits 23:16 at +2
    localparam logic [15:0] SWITCH_ADDR   = 16'hFC70;

endpackage

`default_nettype wire

//--- logic/bus_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module bus_ctrl (
    input  wire                        fpga_clk,
    input  wire                        fpga_rst,
    input  wire                        req_i,
    input  wire minisys_pkg::bus_req_t bus_req_i,
    output logic                       ack_o,
    output logic [31:0]                rd_data_o,
    output logic                       ram_we_o,
    output logic                       ram_re_o,
    output logic                       led_we_o,
    output logic                       pwm_we_o,
    input  wire [31:0]                 ram_data_i,
    input  wire [31:0]                 switch_data_i
);

    minisys_pkg::bus_state_t state;
    minisys_pkg::rd_sel_t    rd_sel;
    minisys_pkg::rd_sel_t    rd_sel_next;

    logic is_io;
    logic is_led;
    logic is_pwm;
    logic is_switch;

    // Address decode against the I/O map
    always_comb begin
        is_io     = (bus_req_i.addr & minisys_pkg::IO_BASE) == minisys_pkg::IO_BASE;
        is_led    = bus_req_i.addr[15:2] == minisys_pkg::LED_ADDR[15:2];     // +0 and +2
        is_pwm    = bus_req_i.addr[15:3] == minisys_pkg::PWM_ADDR_BASE[15:3];
        is_switch = bus_req_i.addr[15:2] == minisys_pkg::SWITCH_ADDR[15:2];

        rd_sel_next = minisys_pkg::RD_NONE;   // LED, PWM and holes read as 0
        if (!bus_req_i.write) begin
            if (!is_io)
                rd_sel_next = minisys_pkg::RD_RAM;
            else if (is_switch)
                rd_sel_next = minisys_pkg::RD_SWITCH;
        end
    end

    always_ff @(posedge fpga_clk) begin
        if (fpga_rst) begin
            state    <= minisys_pkg::BUS_IDLE;
            rd_sel   <= minisys_pkg::RD_NONE;
            ack_o    <= 1'b0;
            ram_we_o <= 1'b0;
            ram_re_o <= 1'b0;
            led_we_o <= 1'b0;
            pwm_we_o <= 1'b0;
        end else begin
            // Strobes last a single cycle
            ram_we_o <= 1'b0;
            ram_re_o <= 1'b0;
            led_we_o <= 1'b0;
            pwm_we_o <= 1'b0;

            case (state)
                minisys_pkg::BUS_IDLE: begin
                    if (req_i) begin
                        ram_we_o <= bus_req_i.write && !is_io;
                        ram_re_o <= !bus_req_i.write && !is_io;
                        led_we_o <= bus_req_i.write && is_led;
                        pwm_we_o <= bus_req_i.write && is_pwm;
                        rd_sel   <= rd_sel_next;
                        state    <= minisys_pkg::BUS_ACCESS;
                    end
                end
                minisys_pkg::BUS_ACCESS: state <= minisys_pkg::BUS_ACK;   // RAM output settles
                minisys_pkg::BUS_ACK: begin
                    if (!ack_o) begin
                        ack_o <= 1'b1;
                    end else if (!req_i) begin
                        ack_o <= 1'b0;
                        state <= minisys_pkg::BUS_IDLE;
                    end
                end
                default: state <= minisys_pkg::BUS_IDLE;
            endcase
        end
    end

    // Read mux, captured once per access and held through the ack
    always_ff @(posedge fpga_clk) begin
        if (state == minisys_pkg::BUS_ACK && !ack_o) begin
            case (rd_sel)
                minisys_pkg::RD_RAM:    rd_data_o <= ram_data_i;
                minisys_pkg::RD_SWITCH: rd_data_o <= switch_data_i;
                default:                rd_data_o <= 32'd0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/data_ram.sv
`timescale 1ns/1ns
`default_nettype none

module data_ram #(
    parameter int RAM_WORDS = 1024
) (
    input  wire                        fpga_clk,
    input  wire                        we_i,
    input  wire                        re_i,
    input  wire minisys_pkg::bus_req_t req_i,
    output logic [31:0]                data_o
);

    localparam int AW = $clog2(RAM_WORDS);

    logic [3:0][7:0] mem [RAM_WORDS];

    logic [13:0]   word_addr;
    logic [AW-1:0] idx;
    logic [3:0]    be;
    logic [31:0]   wlanes;

    // Registered read side
    logic [31:0]         rd_word;
    logic [1:0]          rd_lane;
    logic                rd_sign;
    minisys_pkg::width_t rd_width;

    logic [7:0]  rd_byte;
    logic [15:0] rd_half;

    // Word index wraps modulo the memory depth
    assign word_addr = req_i.addr[15:2] % 14'(RAM_WORDS);
    assign idx       = word_addr[AW-1:0];

    // Byte enables and replicated store data
    always_comb begin
        case (req_i.width)
            minisys_pkg::WIDTH_BYTE: begin
                be     = 4'b0001 << req_i.addr[1:0];
                wlanes = {4{req_i.wdata[7:0]}};
            end
            minisys_pkg::WIDTH_HALF: begin
                be     = req_i.addr[1] ? 4'b1100 : 4'b0011;   // bit 0 ignored
                wlanes = {2{req_i.wdata[15:0]}};
            end
            default: begin
                be     = 4'b1111;
                wlanes = req_i.wdata;
            end
        endcase
    end

    always_ff @(posedge fpga_clk) begin
        for (int i = 0; i < 4; i++) begin
            if (we_i && be[i])
                mem[idx][i] <= wlanes[i*8 +: 8];
        end
        if (re_i) begin
            rd_word  <= mem[idx];
            rd_lane  <= req_i.addr[1:0];
            rd_sign  <= req_i.sign;
            rd_width <= req_i.width;
        end
    end

    assign rd_byte = rd_word[rd_lane*8 +: 8];
    assign rd_half = rd_lane[1] ? rd_word[31:16] : rd_word[15:0];

    // Lane select and extension
    always_comb begin
        case (rd_width)
            minisys_pkg::WIDTH_BYTE: data_o = {{24{rd_sign & rd_byte[7]}}, rd_byte};
            minisys_pkg::WIDTH_HALF: data_o = {{16{rd_sign & rd_half[15]}}, rd_half};
            default:                 data_o = rd_word;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/gpio_port.sv
`timescale 1ns/1ns
`default_nettype none

module gpio_port (
    input  wire         fpga_clk,
    input  wire         fpga_rst,
    input  wire         led_we_i,
    input  wire  [1:0]  addr_i,
    input  wire  [15:0] wdata_i,
    input  wire  [23:0] switch_i,
    output logic [23:0] led_o,
    output logic [31:0] switch_data_o
);

    // Two-flop synchronizer for the board switches
    logic [23:0] switch_meta;
    logic [23:0] switch_sync;

    always_ff @(posedge fpga_clk) begin
        if (fpga_rst) begin
            led_o <= 24'd0;
        end else if (led_we_i) begin
            case (addr_i)
                2'b00:   led_o[15:0]  <= wdata_i;
                2'b10:   led_o[23:16] <= wdata_i[7:0];   // Upper LEDs from low byte
                default: led_o        <= led_o;          // Odd offsets ignored
            endcase
        end
    end

    always_ff @(posedge fpga_clk) begin
        if (fpga_rst) begin
            switch_meta <= 24'd0;
            switch_sync <= 24'd0;
        end else begin
            switch_meta <= switch_i;
            switch_sync <= switch_meta;
        end
    end

    // High half is zero-extended
    always_comb begin
        if (addr_i[1])
            switch_data_o = {24'd0, switch_sync[23:16]};
        else
            switch_data_o = {16'd0, switch_sync[15:0]};
    end

endmodule

`default_nettype wire

//--- logic/pwm_gen.sv
`timescale 1ns/1ns
`default_nettype none

module pwm_gen #(
    parameter int PWM_W = 16
) (
    input  wire         fpga_clk,
    input  wire         fpga_rst,
    input  wire         pwm_we_i,
    input  wire  [2:0]  addr_i,
    input  wire  [15:0] wdata_i,
    output logic        pwm_o
);

    logic [PWM_W-1:0] period;
    logic [PWM_W-1:0] compare;
    logic             enable;
    logic [PWM_W-1:0] cnt;

    // Register file: +0 period, +2 compare, +4 enable
    always_ff @(posedge fpga_clk) begin
        if (fpga_rst) begin
            period  <= '0;
            compare <= '0;
            enable  <= 1'b0;
        end else if (pwm_we_i) begin
            case (addr_i)
                3'd0:    period  <= PWM_W'(wdata_i);
                3'd2:    compare <= PWM_W'(wdata_i);
                3'd4:    enable  <= wdata_i[0];
                default: enable  <= enable;
            endcase
        end
    end

    // Counter runs 0..period, so one frame is period+1 cycles
    always_ff @(posedge fpga_clk) begin
        if (fpga_rst || !enable)
            cnt <= '0;
        else if (cnt >= period)
            cnt <= '0;   // Also catches a period lowered mid-frame
        else
            cnt <= cnt + 1'b1;
    end

    // Registered output keeps the pin glitch free
    always_ff @(posedge fpga_clk) begin
        if (fpga_rst)
            pwm_o <= 1'b0;
        else
            pwm_o <= enable && (cnt < compare);
    end

endmodule

`default_nettype wire

//--- logic/minisys_io.sv
`timescale 1ns/1ns
`default_nettype none

module minisys_io #(
    parameter int RAM_WORDS = 1024,
    parameter int PWM_W     = 16
) (
    input  wire                        fpga_clk,
    input  wire                        fpga_rst,
    input  wire                        req_i,
    input  wire minisys_pkg::bus_req_t bus_req_i,
    output logic                       ack_o,
    output logic [31:0]                rd_data_o,
    input  wire [23:0]                 switch_i,
    output logic [23:0]                led_o,
    output logic                       pwm_o
);

    // Strobes from the controller
    logic ram_we;
    logic ram_re;
    logic led_we;
    logic pwm_we;

    logic [31:0] ram_data;
    logic [31:0] switch_data;

    bus_ctrl bus_ctrl_i (
        .fpga_clk      (fpga_clk),
        .fpga_rst      (fpga_rst),
        .req_i         (req_i),
        .bus_req_i     (bus_req_i),
        .ack_o         (ack_o),
        .rd_data_o     (rd_data_o),
        .ram_we_o      (ram_we),
        .ram_re_o      (ram_re),
        .led_we_o      (led_we),
        .pwm_we_o      (pwm_we),
        .ram_data_i    (ram_data),
        .switch_data_i (switch_data)
    );

    data_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) data_ram_i (
        .fpga_clk (fpga_clk),
        .we_i     (ram_we),
        .re_i     (ram_re),
        .req_i    (bus_req_i),
        .data_o   (ram_data)
    );

    // LED and switch offsets within their 4-byte windows
    gpio_port gpio_port_i (
        .fpga_clk      (fpga_clk),
        .fpga_rst      (fpga_rst),
        .led_we_i      (led_we),
        .addr_i        (bus_req_i.addr[1:0]),
        .wdata_i       (bus_req_i.wdata[15:0]),
        .switch_i      (switch_i),
        .led_o         (led_o),
        .switch_data_o (switch_data)
    );

    pwm_gen #(
        .PWM_W (PWM_W)
    ) pwm_gen_i (
        .fpga_clk (fpga_clk),
        .fpga_rst (fpga_rst),
        .pwm_we_i (pwm_we),
        .addr_i   (bus_req_i.addr[2:0]),   // Register offset 0, 2 or 4
        .wdata_i  (bus_req_i.wdata[15:0]),
        .pwm_o    (pwm_o)
    );

endmodule

`default_nettype wire

//--- bench/minisys_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module minisys_assertions (
    input wire                          fpga_clk,
    input wire                          fpga_rst,
    input wire                          req_i,
    input wire                          ack_i,
    input wire [31:0]                   rd_data_i,
    input wire minisys_pkg::bus_state_t state_i
);

    // Ack stays up until the master drops req
    ack_held: assert property (@(posedge fpga_clk) disable iff (fpga_rst)
        (ack_i && req_i) |=> ack_i)
        else $error("ack_o fell while req_i was still high");

    rd_data_stable: assert property (@(posedge fpga_clk) disable iff (fpga_rst)
        ack_i |=> $stable(rd_data_i))
        else $error("rd_data_o changed while ack_o was high");

    // Ack comes up two cycles after the edge that takes the request
    ack_latency: assert property (@(posedge fpga_clk) disable iff (fpga_rst)
        $rose(ack_i) |-> $past(state_i == minisys_pkg::BUS_IDLE && req_i, 3))
        else $error("ack_o did not rise two cycles after req_i was taken");

    // Only a pending request gets acknowledged
    ack_needs_req: assert property (@(posedge fpga_clk) disable iff (fpga_rst)
        $rose(ack_i) |-> req_i)
        else $error("ack_o rose without req_i");

endmodule

`default_nettype wire

//--- bench/minisys_tb.sv
`timescale 1ns/1ns
`default_nettype none

module minisys_tb;

    localparam int          RAM_WORDS   = 1024;
    localparam int          PWM_W       = 16;
    localparam int          ACK_LATENCY = 2;    // Edges after the one that samples req_i
    localparam int          SYNC_CYCLES = 2;    // Depth of the switch synchronizer
    localparam logic [31:0] RANDOM_SEED = 32'hfcd8_275c;
    localparam string       TEST_FILE   = "bench/minisys_tests.txt";

    // One line of the test file
    typedef struct packed {
        logic [7:0]            op;          // W, R or P
        minisys_pkg::bus_req_t req;
        logic [31:0]           exp_data;
        logic [23:0]           sw;
    } test_line_t;

    logic                  fpga_clk;
    logic                  fpga_rst;
    logic                  req_i;
    minisys_pkg::bus_req_t bus_req_i;
    logic                  ack_o;
    logic [31:0]           rd_data_o;
    logic [23:0]           switch_i;
    logic [23:0]           led_o;
    logic                  pwm_o;

    test_line_t tests[$];
    int         timeout_limit;
    bit         limit_ready;
    int         cycle_count;

    minisys_io #(
        .RAM_WORDS (RAM_WORDS),
        .PWM_W     (PWM_W)
    ) minisys_io_i (
        .fpga_clk  (fpga_clk),
        .fpga_rst  (fpga_rst),
        .req_i     (req_i),
        .bus_req_i (bus_req_i),
        .ack_o     (ack_o),
        .rd_data_o (rd_data_o),
        .switch_i  (switch_i),
        .led_o     (led_o),
        .pwm_o     (pwm_o)
    );

    // Handshake checks on the controller
    bind bus_ctrl minisys_assertions minisys_assertions_i (
        .fpga_clk  (fpga_clk),
        .fpga_rst  (fpga_rst),
        .req_i     (req_i),
        .ack_i     (ack_o),
        .rd_data_i (rd_data_o),
        .state_i   (state)
    );

    initial begin
        fpga_clk = 1'b0;
        forever #4 fpga_clk = ~fpga_clk;   // 8 ns period
    end

    task automatic stop_on_failure();
        $display("Errors found");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Error at %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic load_tests();
        int                fd;
        int                n;
        int                w;
        int                s;
        logic [63:0]       tok;
        logic [8*160-1:0]  rest;
        logic [15:0]       addr;
        logic [31:0]       wdata;
        logic [31:0]       exp_data;
        logic [23:0]       sw;
        test_line_t        t;
        fd = $fopen(TEST_FILE, "r");
        assert (fd != 0) else begin
            $display("Cannot open the test file %s", TEST_FILE);
            stop_on_failure();
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%s", tok);
            if (n != 1)
                break;
            if (tok[7:0] == "#") begin
                void'($fgets(rest, fd));   // Column description
            end else begin
                n = $fscanf(fd, "%h %d %d %h %h %h", addr, w, s, wdata, exp_data, sw);
                assert (n == 6) else begin
                    $display("Test line %0d is malformed", tests.size() + 1);
                    stop_on_failure();
                end
                t.op        = tok[7:0];
                t.req.write = (tok[7:0] == "W");
                t.req.width = minisys_pkg::width_t'(w[1:0]);
                t.req.sign  = s[0];
                t.req.addr  = addr;
                t.req.wdata = wdata;
                t.exp_data  = exp_data;
                t.sw        = sw;
                tests.push_back(t);
            end
        end
        $fclose(fd);
    endtask

    // One four-phase transfer, checked against the file's expected value
    task automatic run_access(input test_line_t t);
        int edges;
        int hold;
        @(posedge fpga_clk);
        req_i     <= 1'b1;
        bus_req_i <= t.req;
        edges = 0;
        @(negedge fpga_clk);
        while (!ack_o) begin
            @(negedge fpga_clk);
            edges++;
        end
        // Count includes the edge that samples req_i
        compare_value("ack_o latency", edges, ACK_LATENCY + 1);
        hold = $urandom % 4;
        repeat (hold) begin
            @(negedge fpga_clk);
            compare_value("ack_o", {31'd0, ack_o}, 32'd1);   // Back-pressure
        end
        if (t.op == "R")
            compare_value("rd_data_o", rd_data_o, t.exp_data);
        else
            compare_value("led_o", {8'd0, led_o}, t.exp_data);
        @(posedge fpga_clk);
        req_i <= 1'b0;
        @(negedge fpga_clk);
        while (ack_o)
            @(negedge fpga_clk);
    endtask

    // High cycles of pwm_o over a window of wdata cycles
    task automatic count_pwm(input test_line_t t);
        int highs;
        highs = 0;
        repeat (t.req.wdata) begin
            @(negedge fpga_clk);
            if (pwm_o)
                highs++;
        end
        compare_value("pwm_o high cycles", highs, t.exp_data);
    endtask

    task automatic run_line(input test_line_t t);
        int idle;
        @(posedge fpga_clk);
        switch_i <= t.sw;
        repeat (SYNC_CYCLES) @(posedge fpga_clk);
        idle = $urandom % 4;
        repeat (idle) @(posedge fpga_clk);
        if (t.op == "P") begin
            count_pwm(t);
        end else begin
            assert (t.op == "W" || t.op == "R") else begin
                $display("Unknown opcode %c in the test file", t.op);
                stop_on_failure();
            end
            run_access(t);
        end
    endtask

    initial begin
        fpga_rst  = 1'b1;
        req_i     = 1'b0;
        bus_req_i = '0;
        switch_i  = 24'd0;
        void'($urandom(RANDOM_SEED));
        load_tests();
        timeout_limit = 20 * tests.size() + 100;
        limit_ready   = 1'b1;
        repeat (3) @(posedge fpga_clk);
        fpga_rst <= 1'b0;
        @(negedge fpga_clk);
        compare_value("ack_o", {31'd0, ack_o}, 32'd0);
        compare_value("led_o", {8'd0, led_o}, 32'd0);
        compare_value("pwm_o", {31'd0, pwm_o}, 32'd0);
        foreach (tests[i])
            run_line(tests[i]);
        $display("No errors");
        $finish;
    end

    // Cycle budget scales with the number of test lines
    initial begin
        cycle_count = 0;
        wait (limit_ready);
        while (cycle_count < timeout_limit) begin
            @(posedge fpga_clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
        stop_on_failure();
    end

endmodule

`default_nettype wire

//--- bench/minisys_tests.txt
# op addr width sign wdata expect switch   (width 0 byte, 1 half, 2 word)
# W checks led_o after the write, R checks rd_data_o, P counts pwm_o highs over wdata cycles
W 0000 2 0 12345678 00000000 000000
R 0000 2 0 00000000 12345678 000000
W 1004 2 0 cafef00d 00000000 000000
R 0004 2 0 00000000 cafef00d 000000
W 0001 0 0 000000a5 00000000 000000
R 0000 2 0 00000000 1234a578 000000
R 0001 0 1 00000000 ffffffa5 000000
R 0001 0 0 00000000 000000a5 000000
W 0002 1 0 00008001 00000000 000000
R 0000 2 0 00000000 8001a578 000000
R 0003 1 1 00000000 ffff8001 000000
R 0000 1 1 00000000 ffffa578 000000
R 0003 0 1 00000000 ffffff80 000000
R 2000 2 0 00000000 8001a578 000000
W fc60 1 0 0000beef 0000beef 000000
W fc62 1 0 00000042 0042beef 000000
R fc60 2 0 00000000 00000000 000000
W 0008 2 0 deadbeef 0042beef 000000
W fc70 1 0 0000ffff 0042beef a55a3c
R fc70 1 0 00000000 00005a3c a55a3c
R fc72 1 0 00000000 000000a5 a55a3c
R fc70 1 0 00000000 00001234 0f1234
W fc30 1 0 00000009 0042beef 0f1234
W fc32 1 0 00000003 0042beef 0f1234
W fc34 1 0 00000001 0042beef 0f1234
P 0000 0 0 0000000a 00000003 0f1234
W fc32 1 0 00000009 0042beef 0f1234
P 0000 0 0 0000000a 00000009 0f1234
W fc34 1 0 00000000 0042beef 0f1234
P 0000 0 0 00000010 00000000 0f1234

//--- sources.f
logic/minisys_pkg.sv
logic/bus_ctrl.sv
logic/data_ram.sv
logic/gpio_port.sv
logic/pwm_gen.sv
logic/minisys_io.sv
bench/minisys_assertions.sv
bench/minisys_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the minisys_io testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -j 0 -f sources.f \
    --top-module minisys_tb -Mdir obj_dir -o minisys_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/minisys_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi

exit 0
